//--- common/soc_map_pkg.sv
package soc_map_pkg;

   // bus widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // top address bits pick the region
   localparam int SLAVE_SEL_W = 2;
   localparam int N_SLAVES = 4;

   // word address widths of the two memories
   localparam int BOOT_ADDR_W = 10;
   localparam int MAIN_ADDR_W = 12;

   typedef enum logic [SLAVE_SEL_W-1:0] {
      SLV_BOOT = 2'd0,
      SLV_MAIN = 2'd1,
      SLV_UART = 2'd2,
      SLV_RST  = 2'd3
   } slave_e;

endpackage

//--- common/soc_bus_pkg.sv
package soc_bus_pkg;
   import soc_map_pkg::*;

   // master request, a write is any nonzero wstrb
   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
   } bus_req_t;

   // slave answer, ready is a one cycle pulse
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              ready;
   } bus_rsp_t;

   // uart word offsets
   typedef enum logic [1:0] {
      UART_TXDATA = 2'd0,
      UART_RXDATA = 2'd1,
      UART_STATUS = 2'd2,
      UART_DIV    = 2'd3
   } uart_reg_e;

   localparam int UART_DIV_W = 16;
   localparam logic [UART_DIV_W-1:0] UART_DIV_RESET = 16'd7;

endpackage

//--- design/soc_interconnect.sv
`timescale 1ns/1ps

module soc_interconnect
   import soc_map_pkg::*;
   import soc_bus_pkg::*;
(
   input  bus_req_t            req,
   input  logic                boot,
   output logic [N_SLAVES-1:0] sel,
   input  bus_rsp_t            slave_rsp [N_SLAVES],
   output bus_rsp_t            rsp
);

   slave_e              region;
   slave_e              target;
   logic [N_SLAVES-1:0] answering;

   assign region = slave_e'(req.addr[ADDR_W-1 -: SLAVE_SEL_W]);

   // region 0 goes to main ram once boot is done
   always_comb begin
      if (!boot && region == SLV_BOOT) begin
         target = SLV_MAIN;
      end else begin
         target = region;
      end
   end

   always_comb begin
      sel = '0;
      if (req.valid) begin
         sel[target] = 1'b1;
      end
   end

   // a second answer would be lost in the mux
   always_comb begin
      for (int i = 0; i < N_SLAVES; i++) begin
         answering[i] = slave_rsp[i].ready;
      end
      assert ($onehot0(answering))
      else $error("more than one slave answering: %h", answering);
   end

   // only the addressed slave can raise ready
   assign rsp = slave_rsp[target];

endmodule

//--- design/soc_ram.sv
`timescale 1ns/1ps

module soc_ram
   import soc_map_pkg::*;
   import soc_bus_pkg::*;
#(
   parameter int WORD_ADDR_W = BOOT_ADDR_W
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     sel,
   input  bus_req_t req,
   output bus_rsp_t rsp
);

   logic [DATA_W-1:0]      mem [2**WORD_ADDR_W];
   logic [WORD_ADDR_W-1:0] word_addr;
   logic [DATA_W-1:0]      rdata_q;
   logic                   ready_q;
   logic                   access;

   assign word_addr = req.addr[WORD_ADDR_W+1:2];
   assign access = sel && !ready_q;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= access;
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         for (int i = 0; i < STRB_W; i++) begin
            if (req.wstrb[i]) begin
               mem[word_addr][8*i +: 8] <= req.wdata[8*i +: 8];
            end
         end
         rdata_q <= mem[word_addr];
      end
   end

   assign rsp.rdata = rdata_q;
   assign rsp.ready = ready_q;

   // master drops or changes the request after each answer
   assert property (@(posedge clk) disable iff (reset) rsp.ready |=> !rsp.ready)
   else $error("ram ready held for two cycles");

endmodule

//--- design/reset_ctrl.sv
`timescale 1ns/1ps

module reset_ctrl
   import soc_bus_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     sel,
   input  bus_req_t req,
   output bus_rsp_t rsp,
   output logic     boot,
   output logic     soft_reset
);

   logic ready_q;
   logic access;

   assign access = sel && !ready_q;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_q <= 1'b0;
         boot <= 1'b1;
         soft_reset <= 1'b0;
      end else begin
         ready_q <= access;
         soft_reset <= 1'b0;
         if (access && req.wstrb != '0) begin
            soft_reset <= req.wdata[0];
            boot <= req.wdata[1];
         end
      end
   end

   // boot flag reads back in bit 1
   always_comb begin
      rsp = '0;
      rsp.rdata[1] = boot;
      rsp.ready = ready_q;
   end

   // pulse lines up with the write answer
   assert property (@(posedge clk) disable iff (reset)
      soft_reset |-> rsp.ready ##1 !soft_reset)
   else $error("soft reset pulse longer than one cycle");

endmodule

//--- uart/uart_regs.sv
`timescale 1ns/1ps

module uart_regs
   import soc_bus_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  sel,
   input  bus_req_t              req,
   output bus_rsp_t              rsp,
   output logic [7:0]            tx_byte,
   output logic                  tx_start,
   input  logic                  tx_busy,
   input  logic [7:0]            rx_byte,
   input  logic                  rx_strobe,
   output logic                  rx_full,
   output logic [UART_DIV_W-1:0] div
);

   uart_reg_e             offset;
   logic                  access;
   logic                  wr;
   logic                  tx_go;
   logic                  ready_q;
   logic [7:0]            rx_data;
   logic [UART_DIV_W-1:0] rdata_q;

   assign offset = uart_reg_e'(req.addr[3:2]);
   assign access = sel && !ready_q;
   assign wr = access && (req.wstrb != '0);
   // a byte already handed over still counts as busy
   assign tx_go = wr && offset == UART_TXDATA && !tx_busy && !tx_start;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_q <= 1'b0;
         tx_start <= 1'b0;
         rx_full <= 1'b0;
         div <= UART_DIV_RESET;
      end else begin
         ready_q <= access;
         tx_start <= tx_go;
         if (wr && offset == UART_DIV) begin
            div <= req.wdata[UART_DIV_W-1:0];
         end
         if (access && !wr && offset == UART_RXDATA) begin
            rx_full <= 1'b0;
         end
         // new byte wins over a read in the same cycle
         if (rx_strobe) begin
            rx_full <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rx_strobe) begin
         rx_data <= rx_byte;
      end
      if (tx_go) begin
         tx_byte <= req.wdata[7:0];
      end
      if (access) begin
         case (offset)
            UART_RXDATA: rdata_q <= {8'd0, rx_data};
            UART_STATUS: rdata_q <= {14'd0, tx_busy | tx_start, rx_full};
            UART_DIV:    rdata_q <= div;
            default:     rdata_q <= '0;
         endcase
      end
   end

   always_comb begin
      rsp = '0;
      rsp.rdata[UART_DIV_W-1:0] = rdata_q;
      rsp.ready = ready_q;
   end

endmodule

//--- uart/uart_serial.sv
`timescale 1ns/1ps

module uart_serial
   import soc_bus_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic [UART_DIV_W-1:0] div,
   input  logic [7:0]            tx_byte,
   input  logic                  tx_start,
   output logic                  tx_busy,
   output logic [7:0]            rx_byte,
   output logic                  rx_strobe,
   input  logic                  rx_full,
   output logic                  txd,
   input  logic                  rxd,
   output logic                  rts,
   input  logic                  cts
);

   typedef enum logic [2:0] {TX_IDLE, TX_WAIT, TX_START, TX_DATA, TX_STOP} tx_state_e;
   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

   tx_state_e             tx_state;
   logic [UART_DIV_W-1:0] tx_cnt;
   logic [2:0]            tx_bit;
   logic [7:0]            tx_shift;

   rx_state_e             rx_state;
   logic [UART_DIV_W-1:0] rx_cnt;
   logic [2:0]            rx_bit;
   logic [7:0]            rx_shift;
   logic [1:0]            rxd_sync;

   assign tx_busy = tx_state != TX_IDLE;
   assign rts = !rx_full;

   // transmit, each bit lasts div+1 clocks
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         tx_state <= TX_IDLE;
         tx_cnt <= '0;
         tx_bit <= '0;
         tx_shift <= '0;
         txd <= 1'b1;
      end else begin
         case (tx_state)
            TX_IDLE: begin
               if (tx_start) begin
                  tx_shift <= tx_byte;
                  tx_state <= TX_WAIT;
               end
            end
            // hold off while the far end is full
            TX_WAIT: begin
               if (cts) begin
                  txd <= 1'b0;
                  tx_cnt <= div;
                  tx_state <= TX_START;
               end
            end
            TX_START: begin
               if (tx_cnt == '0) begin
                  txd <= tx_shift[0];
                  tx_shift <= tx_shift >> 1;
                  tx_bit <= '0;
                  tx_cnt <= div;
                  tx_state <= TX_DATA;
               end else begin
                  tx_cnt <= tx_cnt - 1'b1;
               end
            end
            TX_DATA: begin
               if (tx_cnt == '0) begin
                  tx_cnt <= div;
                  if (tx_bit == 3'd7) begin
                     txd <= 1'b1;
                     tx_state <= TX_STOP;
                  end else begin
                     txd <= tx_shift[0];
                     tx_shift <= tx_shift >> 1;
                     tx_bit <= tx_bit + 1'b1;
                  end
               end else begin
                  tx_cnt <= tx_cnt - 1'b1;
               end
            end
            TX_STOP: begin
               if (tx_cnt == '0) begin
                  tx_state <= TX_IDLE;
               end else begin
                  tx_cnt <= tx_cnt - 1'b1;
               end
            end
            default: tx_state <= TX_IDLE;
         endcase
      end
   end

   // receive, sampled in the middle of each bit
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rxd_sync <= 2'b11;
         rx_state <= RX_IDLE;
         rx_cnt <= '0;
         rx_bit <= '0;
         rx_shift <= '0;
         rx_byte <= '0;
         rx_strobe <= 1'b0;
      end else begin
         rxd_sync <= {rxd_sync[0], rxd};
         rx_strobe <= 1'b0;
         if (rx_state != RX_IDLE) begin
            rx_cnt <= rx_cnt - 1'b1;
         end
         case (rx_state)
            RX_IDLE: begin
               if (!rxd_sync[1]) begin
                  rx_cnt <= div >> 1;
                  rx_state <= RX_START;
               end
            end
            RX_START: begin
               if (rx_cnt == '0) begin
                  // glitch, not a start bit
                  rx_state <= rxd_sync[1] ? RX_IDLE : RX_DATA;
                  rx_cnt <= div;
                  rx_bit <= '0;
               end
            end
            RX_DATA: begin
               if (rx_cnt == '0) begin
                  rx_shift <= {rxd_sync[1], rx_shift[7:1]};
                  rx_cnt <= div;
                  rx_bit <= rx_bit + 1'b1;
                  if (rx_bit == 3'd7) begin
                     rx_state <= RX_STOP;
                  end
               end
            end
            RX_STOP: begin
               if (rx_cnt == '0) begin
                  if (rxd_sync[1]) begin
                     rx_byte <= rx_shift;
                     rx_strobe <= 1'b1;
                  end
                  rx_state <= RX_IDLE;
               end
            end
            default: rx_state <= RX_IDLE;
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (reset) !tx_busy |-> txd)
   else $error("txd low while transmitter idle");

endmodule

//--- design/soc_system.sv
`timescale 1ns/1ps

module soc_system
   import soc_map_pkg::*;
   import soc_bus_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  bus_req_t req,
   output bus_rsp_t rsp,
   output logic     core_reset,
   output logic     uart_txd,
   input  logic     uart_rxd,
   output logic     uart_rts,
   input  logic     uart_cts
);

   logic [N_SLAVES-1:0]   sel;
   bus_rsp_t              slave_rsp [N_SLAVES];
   logic                  boot;
   logic                  soft_reset;

   logic [7:0]            tx_byte;
   logic                  tx_start;
   logic                  tx_busy;
   logic [7:0]            rx_byte;
   logic                  rx_strobe;
   logic                  rx_full;
   logic [UART_DIV_W-1:0] div;

   // core is held by either reset source
   assign core_reset = reset | soft_reset;

   soc_interconnect xbar (
      .req       (req),
      .boot      (boot),
      .sel       (sel),
      .slave_rsp (slave_rsp),
      .rsp       (rsp)
   );

   soc_ram #(.WORD_ADDR_W(BOOT_ADDR_W)) boot_mem (
      .clk   (clk),
      .reset (reset),
      .sel   (sel[SLV_BOOT]),
      .req   (req),
      .rsp   (slave_rsp[SLV_BOOT])
   );

   soc_ram #(.WORD_ADDR_W(MAIN_ADDR_W)) main_mem (
      .clk   (clk),
      .reset (reset),
      .sel   (sel[SLV_MAIN]),
      .req   (req),
      .rsp   (slave_rsp[SLV_MAIN])
   );

   reset_ctrl rst_ctrl (
      .clk        (clk),
      .reset      (reset),
      .sel        (sel[SLV_RST]),
      .req        (req),
      .rsp        (slave_rsp[SLV_RST]),
      .boot       (boot),
      .soft_reset (soft_reset)
   );

   uart_regs uart_if (
      .clk       (clk),
      .reset     (reset),
      .sel       (sel[SLV_UART]),
      .req       (req),
      .rsp       (slave_rsp[SLV_UART]),
      .tx_byte   (tx_byte),
      .tx_start  (tx_start),
      .tx_busy   (tx_busy),
      .rx_byte   (rx_byte),
      .rx_strobe (rx_strobe),
      .rx_full   (rx_full),
      .div       (div)
   );

   uart_serial uart_phy (
      .clk       (clk),
      .reset     (reset),
      .div       (div),
      .tx_byte   (tx_byte),
      .tx_start  (tx_start),
      .tx_busy   (tx_busy),
      .rx_byte   (rx_byte),
      .rx_strobe (rx_strobe),
      .rx_full   (rx_full),
      .txd       (uart_txd),
      .rxd       (uart_rxd),
      .rts       (uart_rts),
      .cts       (uart_cts)
   );

endmodule

//--- verif/soc_system_tb.sv
`timescale 1ns/1ps

module soc_system_tb
   import soc_map_pkg::*;
   import soc_bus_pkg::*;
();

   localparam int CLK_PERIOD = 8;
   localparam int ACCESS_TIMEOUT = 20;
   localparam int POLL_TIMEOUT = 400;
   localparam int N_WORDS = 16;
   localparam int N_UART_BYTES = 6;

   logic     clk;
   logic     reset;
   bus_req_t req;
   bus_rsp_t rsp;
   logic     core_reset;
   logic     uart_txd;
   logic     uart_rxd;
   logic     uart_rts;
   logic     uart_cts;

   int                seed;
   logic [DATA_W-1:0] boot_model [2**BOOT_ADDR_W];
   logic [DATA_W-1:0] main_model [2**MAIN_ADDR_W];
   logic              boot_flag;
   logic              reset_settled;
   logic              soft_req;
   logic [DATA_W-1:0] rd_expect;
   logic [DATA_W-1:0] rd_mask;
   int                offsets [N_WORDS];

   soc_system DUT (
      .clk        (clk),
      .reset      (reset),
      .req        (req),
      .rsp        (rsp),
      .core_reset (core_reset),
      .uart_txd   (uart_txd),
      .uart_rxd   (uart_rxd),
      .uart_rts   (uart_rts),
      .uart_cts   (uart_cts)
   );

   // serial loopback
   assign uart_rxd = uart_txd;
   assign uart_cts = uart_rts;

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("CHECKS FAILED");
      $fatal(1, "simulation stopped");
   endtask

   function automatic logic [ADDR_W-1:0] word_addr(input slave_e region, input int word);
      logic [ADDR_W-1:0] addr;
      addr = ADDR_W'(word) << 2;
      addr[ADDR_W-1 -: SLAVE_SEL_W] = region;
      return addr;
   endfunction

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                    input logic [DATA_W-1:0] wdata,
                                                    input logic [STRB_W-1:0] wstrb);
      logic [DATA_W-1:0] res;
      res = old;
      for (int i = 0; i < STRB_W; i++) begin
         if (wstrb[i]) begin
            res[8*i +: 8] = wdata[8*i +: 8];
         end
      end
      return res;
   endfunction

   // one blocking access, valid low for a cycle before each request
   task automatic transfer(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                           input logic [STRB_W-1:0] wstrb, input logic [DATA_W-1:0] exp_data,
                           input logic [DATA_W-1:0] mask, output logic [DATA_W-1:0] rdata);
      int cycles;
      cycles = 0;
      @(posedge clk);
      #1;
      req.valid = 1'b1;
      req.addr = addr;
      req.wdata = wdata;
      req.wstrb = wstrb;
      rd_expect = exp_data;
      rd_mask = mask;
      soft_req = addr[ADDR_W-1 -: SLAVE_SEL_W] == SLV_RST && wstrb != '0 && wdata[0];
      do begin
         @(posedge clk);
         #1;
         cycles++;
         if (cycles > ACCESS_TIMEOUT) begin
            abort_run($sformatf("no ready for address %h within the timeout", addr));
         end
      end while (!rsp.ready);
      rdata = rsp.rdata;
      req.valid = 1'b0;
   endtask

   task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                             input logic [STRB_W-1:0] wstrb);
      logic [DATA_W-1:0] unused;
      transfer(addr, wdata, wstrb, '0, '0, unused);
   endtask

   task automatic read_check(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp_data,
                             input logic [DATA_W-1:0] mask);
      logic [DATA_W-1:0] unused;
      transfer(addr, '0, '0, exp_data & mask, mask, unused);
   endtask

   task automatic poll_status(input int bit_idx, input logic value);
      logic [DATA_W-1:0] status;
      int polls;
      polls = 0;
      transfer(word_addr(SLV_UART, UART_STATUS), '0, '0, '0, '0, status);
      while (status[bit_idx] !== value) begin
         if (polls == POLL_TIMEOUT) begin
            abort_run($sformatf("uart status bit %0d never reached %0d", bit_idx, value));
         end
         polls++;
         transfer(word_addr(SLV_UART, UART_STATUS), '0, '0, '0, '0, status);
      end
   endtask

   assert property (@(posedge clk) disable iff (reset) $rose(req.valid) |=> rsp.ready)
   else abort_run("ready did not come one cycle after valid");

   assert property (@(posedge clk) disable iff (reset) rsp.ready |=> !rsp.ready)
   else abort_run("ready stayed high for more than one cycle");

   assert property (@(posedge clk) disable iff (reset) rsp.ready |-> $past(req.valid))
   else abort_run("ready seen without a request");

   assert property (@(posedge clk) disable iff (reset)
      rsp.ready |-> (rsp.rdata & rd_mask) == rd_expect)
   else abort_run($sformatf("Fail rsp.rdata got %h expected %h",
      $sampled(rsp.rdata) & $sampled(rd_mask), $sampled(rd_expect)));

   // soft reset pulse lines up with the write answer
   assert property (@(posedge clk) disable iff (reset) rsp.ready && soft_req |-> core_reset)
   else abort_run($sformatf("Fail core_reset got %h expected %h", 1'b0, 1'b1));

   assert property (@(posedge clk) disable iff (reset) core_reset |-> rsp.ready && soft_req)
   else abort_run($sformatf("Fail core_reset got %h expected %h", 1'b1, 1'b0));

   assert property (@(posedge clk) reset && reset_settled |->
      uart_txd && uart_rts && core_reset && !rsp.ready)
   else abort_run("outputs not at their reset values during reset");

   assert property (@(posedge clk) $fell(reset) |->
      uart_txd && uart_rts && !core_reset && !rsp.ready)
   else abort_run("outputs not idle right after reset");

   initial begin
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
      logic [7:0]        tx_val;
      int                idx;
      int                off;
      seed = 32'hea05;
      clk = 1'b0;
      reset = 1'b1;
      req = '0;
      reset_settled = 1'b0;
      soft_req = 1'b0;
      rd_expect = '0;
      rd_mask = '0;
      boot_flag = 1'b1;
      @(posedge clk);
      #1;
      reset_settled = 1'b1;
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;

      // spread offsets across the boot ram range
      for (int i = 0; i < N_WORDS; i++) begin
         offsets[i] = i * 64 + ({$random(seed)} % 64);
         data = $random(seed);
         write_word(word_addr(SLV_BOOT, offsets[i]), data, 4'hf);
         boot_model[offsets[i]] = data;
         data = $random(seed);
         write_word(word_addr(SLV_MAIN, offsets[i]), data, 4'hf);
         main_model[offsets[i]] = data;
      end
      repeat (4 * N_WORDS) begin
         idx = {$random(seed)} % N_WORDS;
         off = offsets[idx];
         data = $random(seed);
         strb = $random(seed);
         if ($random(seed) & 1) begin
            write_word(word_addr(SLV_BOOT, off), data, strb);
            boot_model[off] = merge_bytes(boot_model[off], data, strb);
         end else begin
            write_word(word_addr(SLV_MAIN, off), data, strb);
            main_model[off] = merge_bytes(main_model[off], data, strb);
         end
      end
      for (int i = 0; i < N_WORDS; i++) begin
         read_check(word_addr(SLV_BOOT, offsets[i]), boot_model[offsets[i]], '1);
         read_check(word_addr(SLV_MAIN, offsets[i]), main_model[offsets[i]], '1);
      end

      // boot remap
      read_check(word_addr(SLV_RST, 0), {30'd0, boot_flag, 1'b0}, '1);
      write_word(word_addr(SLV_RST, 0), 32'h0, 4'hf);
      boot_flag = 1'b0;
      read_check(word_addr(SLV_RST, 0), {30'd0, boot_flag, 1'b0}, '1);
      for (int i = 0; i < N_WORDS; i++) begin
         read_check(word_addr(SLV_BOOT, offsets[i]), main_model[offsets[i]], '1);
      end
      data = $random(seed);
      write_word(word_addr(SLV_BOOT, offsets[0]), data, 4'hf);
      main_model[offsets[0]] = data;
      read_check(word_addr(SLV_MAIN, offsets[0]), main_model[offsets[0]], '1);
      write_word(word_addr(SLV_RST, 0), 32'h2, 4'hf);
      boot_flag = 1'b1;
      read_check(word_addr(SLV_RST, 0), {30'd0, boot_flag, 1'b0}, '1);
      for (int i = 0; i < N_WORDS; i++) begin
         read_check(word_addr(SLV_BOOT, offsets[i]), boot_model[offsets[i]], '1);
      end

      // soft reset keeps the boot flag set
      write_word(word_addr(SLV_RST, 0), 32'h3, 4'hf);
      read_check(word_addr(SLV_RST, 0), {30'd0, boot_flag, 1'b0}, '1);

      write_word(word_addr(SLV_UART, UART_DIV), 32'd3, 4'hf);
      read_check(word_addr(SLV_UART, UART_DIV), 32'd3, 32'h0000_ffff);
      repeat (N_UART_BYTES) begin
         tx_val = $random(seed);
         poll_status(1, 1'b0);
         write_word(word_addr(SLV_UART, UART_TXDATA), {24'd0, tx_val}, 4'hf);
         poll_status(0, 1'b1);
         read_check(word_addr(SLV_UART, UART_RXDATA), {24'd0, tx_val}, 32'h0000_00ff);
         read_check(word_addr(SLV_UART, UART_STATUS), 32'h0, 32'h0000_0001);
      end

      repeat (4) @(posedge clk);
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

//--- soc_system.f
common/soc_map_pkg.sv
common/soc_bus_pkg.sv
design/soc_interconnect.sv
design/soc_ram.sv
design/reset_ctrl.sv
uart/uart_regs.sv
uart/uart_serial.sv
design/soc_system.sv
verif/soc_system_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := soc_system_tb
RTL_TOP    := soc_system
FILELIST   := soc_system.f
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := CHECKS FAILED
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
